/* src.f */
design/mips_isa_pkg.sv
design/core_bus_pkg.sv
design/mem_port_if.sv
design/inst_stream_if.sv
design/fetch_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/bus_arbiter.sv
design/mini_mips_top.sv
verification/tb_clock_gen.sv
verification/tb_mini_mips.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mini_mips
FILELIST  = src.f
BUILD_DIR = obj_dir
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_mini_mips.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mini_mips;

    localparam int          N_INSTR    = 200;
    localparam int          MEM_WORDS  = 2048;  // 8 KB, code at 0, data at 0x1000
    localparam int          SEED       = 29429;
    localparam int          MAX_CYCLES = N_INSTR * 12 + 200;
    localparam logic [31:0] DATA_BASE  = 32'h0000_1000;
    localparam logic [31:0] HALT       = {mips_isa_pkg::OP_BEQ, 10'd0, 16'hffff};  // beq $0,$0,-1

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [3:0]  wb_sel;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic [31:0] dbg_pc;
    logic        dbg_wen;
    logic [4:0]  dbg_wnum;
    logic [31:0] dbg_wdata;

    logic [31:0] prog [N_INSTR];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_dat [$];
    logic [31:0] st_adr [$];
    logic [31:0] st_dat [$];
    int          n_val_err;
    int          n_proto_err;
    int          n_writes;
    int          n_exp_writes;
    int          cycles = 0;
    int          ack_delay;
    bit          out_of_reset = 1'b0;
    bit          busy;
    bit          pend;
    bit          first_seen;
    logic [31:0] p_adr;
    logic [31:0] p_dat;
    logic        p_we;

    tb_clock_gen clk_gen0 (.clk_o(clk), .arst_n_o(arst_n));

    mini_mips_top uut (
        .cpu_clk_50M         (clk),
        .arst_n_i            (arst_n),
        .wb_cyc_o            (wb_cyc),
        .wb_stb_o            (wb_stb),
        .wb_we_o             (wb_we),
        .wb_adr_o            (wb_adr),
        .wb_dat_o            (wb_wdat),
        .wb_sel_o            (wb_sel),
        .wb_dat_i            (wb_rdat),
        .wb_ack_i            (wb_ack),
        .debug_wb_pc_o       (dbg_pc),
        .debug_wb_rf_wen_o   (dbg_wen),
        .debug_wb_rf_wnum_o  (dbg_wnum),
        .debug_wb_rf_wdata_o (dbg_wdata)
    );

    function automatic logic [31:0] fill_word(int idx);
        return 32'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pick_funct(int k);
        case (k)
            0:       return mips_isa_pkg::FN_ADDU;
            1:       return mips_isa_pkg::FN_SUBU;
            2:       return mips_isa_pkg::FN_AND;
            3:       return mips_isa_pkg::FN_OR;
            4:       return mips_isa_pkg::FN_XOR;
            default: return mips_isa_pkg::FN_SLT;
        endcase
    endfunction

    task automatic gen_program();
        int          kind;
        int          room;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int i = 0; i < N_INSTR - 1; i++) begin
            kind = $urandom % 10;
            rs   = 5'($urandom % 8);  // Few registers, so branches often compare equal
            rt   = 5'($urandom % 8);
            rd   = 5'($urandom % 8);
            imm  = 16'($urandom % 16) - 16'd8;
            case (kind)
                0, 1, 2, 3, 4:
                    prog[i] = {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0,
                               pick_funct($urandom % 6)};
                5: prog[i] = enc_i(mips_isa_pkg::OP_ADDIU, rs, rt, imm);
                6: prog[i] = enc_i(mips_isa_pkg::OP_ORI, rs, rt, imm);
                7: prog[i] = enc_i(mips_isa_pkg::OP_LUI, 5'd0, rt, 16'($urandom));
                8: prog[i] = enc_i(($urandom % 2) ? mips_isa_pkg::OP_SW : mips_isa_pkg::OP_LW,
                                   5'd0, rt, 16'(DATA_BASE + 32'(4 * ($urandom % 16))));
                default: begin
                    room    = N_INSTR - 2 - i;  // Forward only, never past the halt
                    imm     = 16'($urandom % ((room < 4 ? room : 4) + 1));
                    prog[i] = enc_i(($urandom % 2) ? mips_isa_pkg::OP_BNE : mips_isa_pkg::OP_BEQ,
                                    rs, rt, imm);
                end
            endcase
        end
        prog[N_INSTR-1] = HALT;
    endtask

    task automatic record_write(logic [31:0] pc, logic [4:0] num, logic [31:0] val);
        if (num != 5'd0) begin
            ref_regs[num] = val;
            exp_pc.push_back(pc);
            exp_num.push_back(num);
            exp_dat.push_back(val);
        end
    endtask

    // In-order ISA model of the generated program
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] ea;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        pc    = mips_isa_pkg::RESET_PC;
        steps = 0;
        while (prog[pc[9:2]] != HALT && steps < N_INSTR) begin
            w   = prog[pc[9:2]];
            a   = ref_regs[w[25:21]];
            b   = ref_regs[w[20:16]];
            sx  = {{16{w[15]}}, w[15:0]};
            ea  = a + sx;
            nxt = pc + 32'd4;
            case (w[31:26])
                mips_isa_pkg::OP_SPECIAL: begin
                    case (w[5:0])
                        mips_isa_pkg::FN_ADDU: record_write(pc, w[15:11], a + b);
                        mips_isa_pkg::FN_SUBU: record_write(pc, w[15:11], a - b);
                        mips_isa_pkg::FN_AND:  record_write(pc, w[15:11], a & b);
                        mips_isa_pkg::FN_OR:   record_write(pc, w[15:11], a | b);
                        mips_isa_pkg::FN_XOR:  record_write(pc, w[15:11], a ^ b);
                        default: record_write(pc, w[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
                    endcase
                end
                mips_isa_pkg::OP_ADDIU: record_write(pc, w[20:16], ea);
                mips_isa_pkg::OP_ORI:   record_write(pc, w[20:16], a | {16'h0000, w[15:0]});
                mips_isa_pkg::OP_LUI:   record_write(pc, w[20:16], {w[15:0], 16'h0000});
                mips_isa_pkg::OP_LW:    record_write(pc, w[20:16], ref_mem[ea[12:2]]);
                mips_isa_pkg::OP_SW: begin
                    ref_mem[ea[12:2]] = b;
                    st_adr.push_back(ea);
                    st_dat.push_back(b);
                end
                mips_isa_pkg::OP_BEQ: if (a == b) nxt = pc + 32'd4 + {sx[29:0], 2'b00};
                default:              if (a != b) nxt = pc + 32'd4 + {sx[29:0], 2'b00};
            endcase
            pc    = nxt;
            steps = steps + 1;
        end
        n_exp_writes = exp_num.size();
    endtask

    task automatic check_stable();
        assert (wb_stb) else begin
            n_proto_err++;
            $display("Strobe dropped before the transfer was acknowledged");
        end
        assert (wb_adr == p_adr) else begin
            n_val_err++;
            $display("[FAIL] wb_adr_o: got 0x%h, expected 0x%h", wb_adr, p_adr);
        end
        assert (wb_we == p_we) else begin
            n_val_err++;
            $display("[FAIL] wb_we_o: got 0x%h, expected 0x%h", wb_we, p_we);
        end
        assert (wb_wdat == p_dat) else begin
            n_val_err++;
            $display("[FAIL] wb_dat_o: got 0x%h, expected 0x%h", wb_wdat, p_dat);
        end
    endtask

    task automatic serve_transfer();
        wb_rdat = '0;
        assert (wb_adr < 32'(MEM_WORDS * 4)) else begin
            n_proto_err++;
            $display("Bus access outside the memory at 0x%h", wb_adr);
        end
        if (!wb_we) begin
            wb_rdat = mem[wb_adr[12:2]];
        end else begin
            mem[wb_adr[12:2]] = wb_wdat;
            assert (wb_sel == 4'hf) else begin
                n_val_err++;
                $display("[FAIL] wb_sel_o: got 0x%h, expected 0x%h", wb_sel, 4'hf);
            end
            assert (st_adr.size() != 0) else begin
                n_proto_err++;
                $display("Store to 0x%h that the program never issues", wb_adr);
            end
            if (st_adr.size() != 0) begin
                assert (wb_adr == st_adr[0]) else begin
                    n_val_err++;
                    $display("[FAIL] wb_adr_o: got 0x%h, expected 0x%h", wb_adr, st_adr[0]);
                end
                assert (wb_wdat == st_dat[0]) else begin
                    n_val_err++;
                    $display("[FAIL] wb_dat_o: got 0x%h, expected 0x%h", wb_wdat, st_dat[0]);
                end
                void'(st_adr.pop_front());
                void'(st_dat.pop_front());
            end
        end
    endtask

    task automatic check_debug_write();
        assert (exp_num.size() != 0) else begin
            n_proto_err++;
            $display("Unexpected register write to r%0d at pc 0x%h", dbg_wnum, dbg_pc);
        end
        if (exp_num.size() != 0) begin
            assert (dbg_pc == exp_pc[0]) else begin
                n_val_err++;
                $display("[FAIL] debug_wb_pc_o: got 0x%h, expected 0x%h", dbg_pc, exp_pc[0]);
            end
            assert (dbg_wnum == exp_num[0]) else begin
                n_val_err++;
                $display("[FAIL] debug_wb_rf_wnum_o: got 0x%h, expected 0x%h",
                         dbg_wnum, exp_num[0]);
            end
            assert (dbg_wdata == exp_dat[0]) else begin
                n_val_err++;
                $display("[FAIL] debug_wb_rf_wdata_o: got 0x%h, expected 0x%h",
                         dbg_wdata, exp_dat[0]);
            end
            void'(exp_pc.pop_front());
            void'(exp_num.pop_front());
            void'(exp_dat.pop_front());
        end
        n_writes++;
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            out_of_reset <= 1'b1;
            cycles       <= cycles + 1;
        end
    end

    // Wishbone slave and monitors, all on the falling edge
    always @(negedge clk) begin
        if (!out_of_reset) begin
            assert (!wb_cyc && !dbg_wen) else begin
                n_proto_err++;
                $display("Bus cycle or register write during reset");
            end
        end
        if (pend) begin
            check_stable();
        end
        if (wb_ack) begin
            wb_ack = 1'b0;
            assert (!wb_cyc) else begin
                n_proto_err++;
                $display("Bus cycle held without an idle cycle after ack");
            end
        end else if (wb_cyc && wb_stb) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                assert (wb_adr == mips_isa_pkg::RESET_PC && !wb_we) else begin
                    n_val_err++;
                    $display("[FAIL] wb_adr_o: got 0x%h, expected 0x%h (read)",
                             wb_adr, mips_isa_pkg::RESET_PC);
                end
            end
            if (!busy) begin
                busy      = 1'b1;
                ack_delay = $urandom % 4;
            end
            if (ack_delay == 0) begin
                serve_transfer();
                wb_ack = 1'b1;
                busy   = 1'b0;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
        pend  = wb_cyc && wb_stb && !wb_ack;
        p_adr = wb_adr;
        p_dat = wb_wdat;
        p_we  = wb_we;
        if (dbg_wen) begin
            check_debug_write();
        end
    end

    initial begin
        wb_rdat      = '0;
        wb_ack       = 1'b0;
        n_val_err    = 0;
        n_proto_err  = 0;
        n_writes     = 0;
        ack_delay    = 0;
        busy         = 1'b0;
        pend         = 1'b0;
        first_seen   = 1'b0;
        void'($urandom(SEED));
        gen_program();
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k]     = (k < N_INSTR) ? prog[k] : fill_word(k);
            ref_mem[k] = mem[k];
        end
        run_model();
        wait (out_of_reset);
        while ((exp_num.size() != 0 || st_adr.size() != 0) && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (cycles >= MAX_CYCLES) begin
            n_proto_err++;
            $display("Timeout after %0d cycles, %0d writes and %0d stores still missing",
                     cycles, exp_num.size(), st_adr.size());
        end else begin
            repeat (20) @(posedge clk);  // Catch stray writes from the halt loop
        end
        assert (n_writes == n_exp_writes) else begin
            n_val_err++;
            $display("[FAIL] debug_wb_rf_wen_o count: got 0x%h, expected 0x%h",
                     n_writes, n_exp_writes);
        end
        $display("Errors: %0d value, %0d protocol, %0d of %0d writes seen",
                 n_val_err, n_proto_err, n_writes, n_exp_writes);
        if (n_val_err == 0 && n_proto_err == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;  // Released away from the active edge
    end

    always #10 clk_o = ~clk_o;  // 20 ns period

endmodule

`default_nettype wire

/* design/mini_mips_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mini_mips_top (
    input  logic                                cpu_clk_50M,
    input  logic                                arst_n_i,

    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [core_bus_pkg::ADR_W-1:0]      wb_adr_o,
    output logic [core_bus_pkg::DAT_W-1:0]      wb_dat_o,
    output logic [core_bus_pkg::SEL_W-1:0]      wb_sel_o,
    input  logic [core_bus_pkg::DAT_W-1:0]      wb_dat_i,
    input  logic                                wb_ack_i,

    output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic                                debug_wb_rf_wen_o,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

    mem_port_if    fetch_port ();
    mem_port_if    data_port ();
    inst_stream_if stream ();

    fetch_unit fetch_unit0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .bus         (fetch_port.requester),
        .stream      (stream.producer)
    );

    exec_unit exec_unit0 (
        .cpu_clk_50M   (cpu_clk_50M),
        .arst_n_i      (arst_n_i),
        .stream        (stream.consumer),
        .bus           (data_port.requester),
        .debug_pc_o    (debug_wb_pc_o),
        .debug_wen_o   (debug_wb_rf_wen_o),
        .debug_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wdata_o (debug_wb_rf_wdata_o)
    );

    bus_arbiter bus_arbiter0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .fetch_port  (fetch_port.arbiter),
        .data_port   (data_port.arbiter),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i)
    );

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic                           cpu_clk_50M,
    input  logic                           arst_n_i,
    mem_port_if.arbiter                    fetch_port,
    mem_port_if.arbiter                    data_port,
    output logic                           wb_cyc_o,
    output logic                           wb_stb_o,
    output logic                           wb_we_o,
    output logic [core_bus_pkg::ADR_W-1:0] wb_adr_o,
    output logic [core_bus_pkg::DAT_W-1:0] wb_dat_o,
    output logic [core_bus_pkg::SEL_W-1:0] wb_sel_o,
    input  logic [core_bus_pkg::DAT_W-1:0] wb_dat_i,
    input  logic                           wb_ack_i
);

    core_bus_pkg::grant_e gnt_q;
    logic                 owned_q;  // Bus locked until ack
    logic                 to_data;

    assign to_data = (gnt_q == core_bus_pkg::GNT_DATA);

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gnt_q   <= core_bus_pkg::GNT_FETCH;
            owned_q <= 1'b0;
        end else if (!owned_q) begin
            if (data_port.cyc) begin
                gnt_q   <= core_bus_pkg::GNT_DATA;  // Data wins a tie
                owned_q <= 1'b1;
            end else if (fetch_port.cyc) begin
                gnt_q   <= core_bus_pkg::GNT_FETCH;
                owned_q <= 1'b1;
            end
        end else if (wb_ack_i) begin
            owned_q <= 1'b0;
        end
    end

    assign wb_cyc_o = owned_q && (to_data ? data_port.cyc : fetch_port.cyc);
    assign wb_stb_o = owned_q && (to_data ? data_port.stb : fetch_port.stb);
    assign wb_we_o  = to_data ? data_port.we    : fetch_port.we;
    assign wb_adr_o = to_data ? data_port.adr   : fetch_port.adr;
    assign wb_dat_o = to_data ? data_port.dat_w : fetch_port.dat_w;
    assign wb_sel_o = to_data ? data_port.sel   : fetch_port.sel;

    assign data_port.ack    = owned_q && to_data && wb_ack_i;
    assign fetch_port.ack   = owned_q && !to_data && wb_ack_i;
    assign data_port.dat_r  = to_data ? wb_dat_i : '0;
    assign fetch_port.dat_r = to_data ? '0 : wb_dat_i;

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic                                cpu_clk_50M,
    input  logic                                arst_n_i,
    inst_stream_if.consumer                     stream,
    mem_port_if.requester                       bus,
    output logic [mips_isa_pkg::XLEN-1:0]       debug_pc_o,
    output logic                                debug_wen_o,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] debug_wnum_o,
    output logic [mips_isa_pkg::XLEN-1:0]       debug_wdata_o
);

    mips_isa_pkg::instr_t                inst;
    mips_isa_pkg::alu_op_e               alu_op;
    logic [mips_isa_pkg::XLEN-1:0]       rd1;
    logic [mips_isa_pkg::XLEN-1:0]       rd2;
    logic [mips_isa_pkg::XLEN-1:0]       imm_sext;
    logic [mips_isa_pkg::XLEN-1:0]       src_b;
    logic [mips_isa_pkg::XLEN-1:0]       alu_res;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] dst;
    logic                                use_imm;
    logic                                zero_ext;
    logic                                alu_wr;
    logic                                is_load;
    logic                                is_store;
    logic                                is_beq;
    logic                                is_bne;
    logic                                taken;
    logic                                ld_done;
    logic                                rf_we;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] rf_wa;
    logic [mips_isa_pkg::XLEN-1:0]       rf_wd;
    logic [mips_isa_pkg::XLEN-1:0]       wr_pc;
    logic                                mem_q;     // Load or store on the bus
    logic                                mem_we_q;
    logic [mips_isa_pkg::XLEN-1:0]       adr_q;
    logic [mips_isa_pkg::XLEN-1:0]       dat_q;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] ld_wa_q;
    logic [mips_isa_pkg::XLEN-1:0]       mem_pc_q;

    assign inst     = stream.instr;
    assign imm_sext = {{16{inst.i_view.imm16[15]}}, inst.i_view.imm16};

    always_comb begin
        alu_op   = mips_isa_pkg::ALU_ADD;
        dst      = inst.i_view.rt;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        alu_wr   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        case (inst.r_view.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                dst     = inst.r_view.rd;
                use_imm = 1'b0;
                alu_wr  = 1'b1;
                case (inst.r_view.funct)
                    mips_isa_pkg::FN_ADDU: alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::FN_SLT:  alu_op = mips_isa_pkg::ALU_SLT;
                    default:               alu_wr = 1'b0;  // Unsupported funct is a no-op
                endcase
            end
            mips_isa_pkg::OP_ADDIU: alu_wr = 1'b1;
            mips_isa_pkg::OP_ORI: begin
                alu_op   = mips_isa_pkg::ALU_OR;
                zero_ext = 1'b1;
                alu_wr   = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                alu_op = mips_isa_pkg::ALU_LUI;
                alu_wr = 1'b1;
            end
            mips_isa_pkg::OP_LW:  is_load  = 1'b1;
            mips_isa_pkg::OP_SW:  is_store = 1'b1;
            mips_isa_pkg::OP_BEQ: is_beq   = 1'b1;
            mips_isa_pkg::OP_BNE: is_bne   = 1'b1;
            default:              alu_wr   = 1'b0;
        endcase
    end

    assign src_b = !use_imm ? rd2 :
                   zero_ext ? {16'h0000, inst.i_view.imm16} : imm_sext;

    always_comb begin
        case (alu_op)
            mips_isa_pkg::ALU_ADD: alu_res = rd1 + src_b;
            mips_isa_pkg::ALU_SUB: alu_res = rd1 - src_b;
            mips_isa_pkg::ALU_AND: alu_res = rd1 & src_b;
            mips_isa_pkg::ALU_OR:  alu_res = rd1 | src_b;
            mips_isa_pkg::ALU_XOR: alu_res = rd1 ^ src_b;
            mips_isa_pkg::ALU_SLT: alu_res = {31'd0, $signed(rd1) < $signed(src_b)};
            mips_isa_pkg::ALU_LUI: alu_res = {inst.i_view.imm16, 16'h0000};
            default:               alu_res = '0;
        endcase
    end

    assign taken = (is_beq && (rd1 == rd2)) || (is_bne && (rd1 != rd2));

    assign stream.accept   = stream.valid && !mem_q;
    assign stream.redirect = stream.accept && taken;
    assign stream.target   = stream.pc + 32'd4 + {imm_sext[29:0], 2'b00};

    // Load data and ALU results share the single write port
    assign ld_done = mem_q && bus.ack && !mem_we_q;
    assign rf_wa   = ld_done ? ld_wa_q : dst;
    assign rf_wd   = ld_done ? bus.dat_r : alu_res;
    assign wr_pc   = ld_done ? mem_pc_q : stream.pc;
    assign rf_we   = (ld_done || (stream.accept && alu_wr)) && (rf_wa != '0);

    reg_file reg_file0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .ra1_i       (inst.r_view.rs),
        .ra2_i       (inst.r_view.rt),
        .wa_i        (rf_wa),
        .we_i        (rf_we),
        .wd_i        (rf_wd),
        .rd1_o       (rd1),
        .rd2_o       (rd2)
    );

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q       <= 1'b0;
            debug_wen_o <= 1'b0;
        end else begin
            if (stream.accept && (is_load || is_store)) begin
                mem_q <= 1'b1;
            end else if (bus.ack) begin
                mem_q <= 1'b0;
            end
            debug_wen_o <= rf_we;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (stream.accept) begin
            adr_q    <= rd1 + imm_sext;
            dat_q    <= rd2;
            mem_we_q <= is_store;
            ld_wa_q  <= inst.i_view.rt;
            mem_pc_q <= stream.pc;
        end
        if (rf_we) begin
            debug_pc_o    <= wr_pc;
            debug_wnum_o  <= rf_wa;
            debug_wdata_o <= rf_wd;
        end
    end

    assign bus.cyc   = mem_q;
    assign bus.stb   = mem_q;
    assign bus.we    = mem_we_q;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_q;
    assign bus.sel   = '1;  // Full words only

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                                cpu_clk_50M,
    input  logic                                arst_n_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ra1_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ra2_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] wa_i,
    input  logic                                we_i,
    input  logic [mips_isa_pkg::XLEN-1:0]       wd_i,
    output logic [mips_isa_pkg::XLEN-1:0]       rd1_o,
    output logic [mips_isa_pkg::XLEN-1:0]       rd2_o
);

    logic [mips_isa_pkg::XLEN-1:0] regs [1:31];  // $zero has no storage

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic            cpu_clk_50M,
    input  logic            arst_n_i,
    mem_port_if.requester   bus,
    inst_stream_if.producer stream
);

    logic [mips_isa_pkg::XLEN-1:0] pc_q;       // Next sequential fetch address
    logic [mips_isa_pkg::XLEN-1:0] req_adr_q;
    logic                          req_q;
    logic                          stale_q;    // Read in flight belongs to a flushed path
    logic                          buf_valid_q;
    mips_isa_pkg::instr_t          buf_instr_q;
    logic [mips_isa_pkg::XLEN-1:0] buf_pc_q;
    logic                          take;
    logic                          issue;
    logic                          keep_word;
    logic [mips_isa_pkg::XLEN-1:0] fetch_adr;

    assign take      = stream.valid && stream.accept;
    assign issue     = !req_q && (!buf_valid_q || take);
    assign fetch_adr = stream.redirect ? stream.target : pc_q;
    assign keep_word = bus.ack && !stale_q && !stream.redirect;

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q        <= mips_isa_pkg::RESET_PC;
            req_q       <= 1'b0;
            stale_q     <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            if (issue) begin
                pc_q <= fetch_adr + 32'd4;
            end else if (stream.redirect) begin
                pc_q <= stream.target;
            end
            if (issue) begin
                req_q <= 1'b1;
            end else if (bus.ack) begin
                req_q <= 1'b0;  // Gives the idle cycle between transfers
            end
            if (bus.ack) begin
                stale_q <= 1'b0;
            end else if (stream.redirect && req_q) begin
                stale_q <= 1'b1;
            end
            if (keep_word) begin
                buf_valid_q <= 1'b1;
            end else if (take) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (issue) begin
            req_adr_q <= fetch_adr;
        end
        if (keep_word) begin
            buf_instr_q <= mips_isa_pkg::instr_t'(bus.dat_r);
            buf_pc_q    <= req_adr_q;
        end
    end

    assign bus.cyc   = req_q;
    assign bus.stb   = req_q;
    assign bus.we    = 1'b0;
    assign bus.adr   = req_adr_q;
    assign bus.dat_w = '0;
    assign bus.sel   = '1;

    assign stream.valid = buf_valid_q;
    assign stream.instr = buf_instr_q;
    assign stream.pc    = buf_pc_q;

endmodule

`default_nettype wire

/* design/inst_stream_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface inst_stream_if;

    logic                          valid;
    mips_isa_pkg::instr_t          instr;
    logic [mips_isa_pkg::XLEN-1:0] pc;
    logic                          accept;
    logic                          redirect;  // Taken branch, flush and refetch
    logic [mips_isa_pkg::XLEN-1:0] target;

    modport producer (
        output valid, instr, pc,
        input  accept, redirect, target
    );

    modport consumer (
        input  valid, instr, pc,
        output accept, redirect, target
    );

endinterface

`default_nettype wire

/* design/mem_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;

    logic                           cyc;
    logic                           stb;
    logic                           we;
    logic [core_bus_pkg::ADR_W-1:0] adr;
    logic [core_bus_pkg::DAT_W-1:0] dat_w;
    logic [core_bus_pkg::SEL_W-1:0] sel;
    logic [core_bus_pkg::DAT_W-1:0] dat_r;
    logic                           ack;

    modport requester (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport arbiter (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* design/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

    localparam int ADR_W = 32;
    localparam int DAT_W = 32;
    localparam int SEL_W = 4;  // One strobe per byte lane

    typedef enum logic {
        GNT_FETCH = 1'b0,
        GNT_DATA  = 1'b1
    } grant_e;

endpackage

`default_nettype wire

/* design/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_type_t;

    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire
